//--- rtl/fetchPkg.sv
/*
 * Fetch front end shared definitions
 * Widths, queue sizing, opcode constants, interrupt vector word
 * and the types used across fetch, queue and instruction buffer
 */
package fetchPkg;

   // Datapath widths
   localparam int InstrWidth = 32;
   localparam int AddrWidth = 16;

   // Fetch queue sizing, depth must be a power of two
   localparam int QueueDepth = 4;
   localparam int QueuePtrWidth = $clog2(QueueDepth);
   // Counts 0 up to QueueDepth inclusive
   localparam int CreditWidth = $clog2(QueueDepth + 1);

   typedef logic [InstrWidth-1:0] instrWordT;
   typedef logic [AddrWidth-1:0] addrT;
   typedef logic [5:0] opcodeT;
   typedef logic [4:0] regIdxT;
   typedef logic [10:0] altT;

   // Prefix and control flow opcodes
   localparam opcodeT OpImm = 6'o54;
   localparam opcodeT OpRtd = 6'o55;
   localparam opcodeT OpBruA = 6'o46;
   localparam opcodeT OpBruB = 6'o56;
   localparam opcodeT OpBccA = 6'o47;
   localparam opcodeT OpBccB = 6'o57;

   // Two-cycle execute opcodes
   localparam opcodeT OpMulA = 6'o20;
   localparam opcodeT OpMulB = 6'o30;
   localparam opcodeT OpBsfA = 6'o21;
   localparam opcodeT OpBsfB = 6'o31;

   // Branch to interrupt vector 0x10, link in r14
   localparam instrWordT IntVectorOp = 32'hB9CE0010;

   // Load/store class has opcode bits 5:4 set
   function automatic logic isLoadStore(input opcodeT op);
      return op[5:4] == 2'b11;
   endfunction

   // Within that class bit 2 picks store over load
   function automatic logic isStore(input opcodeT op);
      return isLoadStore(op) && op[2];
   endfunction

endpackage

//--- rtl/fetchUnit.sv
/*
 * Fetch unit
 * Walks the program counter through instruction memory and pushes
 * each returned word into the fetch queue, paced by queue credits
 */
module fetchUnit
   import fetchPkg::*;
(
   input  logic      gclk,
   input  logic      grst,
   output logic      imemReq,
   output addrT      imemAddr,
   input  instrWordT imemData,
   output logic      pushValid,
   output addrT      pushAddr,
   output instrWordT pushWord,
   input  logic      creditReturn
);

   addrT pc;
   logic [CreditWidth-1:0] creditCount;
   logic fetchRun;
   logic reqPending;
   addrT reqAddr;
   logic [CreditWidth-1:0] creditInc;
   logic [CreditWidth-1:0] creditDec;

   // Held off for one cycle out of reset
   always_ff @(posedge gclk) begin
      if (grst) begin
         fetchRun <= 1'b0;
      end else begin
         fetchRun <= 1'b1;
      end
   end

   // Request whenever a queue entry is guaranteed free
   assign imemReq = fetchRun && (creditCount != '0);
   assign imemAddr = pc;

   // Program counter, one word per request
   always_ff @(posedge gclk) begin
      if (grst) begin
         pc <= '0;
      end else if (imemReq) begin
         pc <= pc + addrT'(4);
      end
   end

   // Return and spend can land in the same cycle
   assign creditInc = CreditWidth'(creditReturn);
   assign creditDec = CreditWidth'(imemReq);

   always_ff @(posedge gclk) begin
      if (grst) begin
         creditCount <= CreditWidth'(QueueDepth);
      end else begin
         creditCount <= creditCount + creditInc - creditDec;
      end
   end

   // Track the outstanding request flag
   always_ff @(posedge gclk) begin
      if (grst) begin
         reqPending <= 1'b0;
      end else begin
         reqPending <= imemReq;
      end
   end

   // Address travels alongside the returning word
   always_ff @(posedge gclk) begin
      if (imemReq) begin
         reqAddr <= imemAddr;
      end
   end

   // Memory answers one cycle after the request
   assign pushValid = reqPending;
   assign pushAddr = reqAddr;
   assign pushWord = imemData;

endmodule

//--- rtl/fetchQueue.sv
/*
 * Fetch queue
 * Circular buffer of address and word pairs between fetch unit
 * and instruction buffer; each pop hands one credit back
 */
module fetchQueue
   import fetchPkg::*;
(
   input  logic      gclk,
   input  logic      grst,
   input  logic      pushValid,
   input  addrT      pushAddr,
   input  instrWordT pushWord,
   output logic      headValid,
   output addrT      headAddr,
   output instrWordT headWord,
   input  logic      pop,
   output logic      creditReturn
);

   addrT addrMem [QueueDepth];
   instrWordT wordMem [QueueDepth];
   logic [QueuePtrWidth-1:0] wrPtr;
   logic [QueuePtrWidth-1:0] rdPtr;
   logic [CreditWidth-1:0] count;
   logic popTake;

   // Oldest entry drives the head
   assign headValid = count != '0;
   assign headAddr = addrMem[rdPtr];
   assign headWord = wordMem[rdPtr];

   // Ignore a pop on an empty queue
   assign popTake = pop && headValid;

   // Storage, credits keep writes off live entries
   always_ff @(posedge gclk) begin
      if (pushValid) begin
         addrMem[wrPtr] <= pushAddr;
         wordMem[wrPtr] <= pushWord;
      end
   end

   // Pointers wrap at the power-of-two depth
   always_ff @(posedge gclk) begin
      if (grst) begin
         wrPtr <= '0;
         rdPtr <= '0;
      end else begin
         if (pushValid) begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (popTake) begin
            rdPtr <= rdPtr + 1'b1;
         end
      end
   end

   // Occupancy, push and pop together leave it unchanged
   always_ff @(posedge gclk) begin
      if (grst) begin
         count <= '0;
      end else if (pushValid && !popTake) begin
         count <= count + 1'b1;
      end else if (popTake && !pushValid) begin
         count <= count - 1'b1;
      end
   end

   // One credit per freed entry, a cycle after the pop
   always_ff @(posedge gclk) begin
      if (grst) begin
         creditReturn <= 1'b0;
      end else begin
         creditReturn <= popTake;
      end
   end

endmodule

//--- rtl/instrBuffer.sv
/*
 * Instruction buffer
 * Decodes queue words into the issue register, merges IMM prefixes,
 * injects the interrupt vector and spaces out two-cycle instructions
 */
module instrBuffer
   import fetchPkg::*;
(
   input  logic      gclk,
   input  logic      grst,
   input  logic      headValid,
   input  addrT      headAddr,
   input  instrWordT headWord,
   output logic      pop,
   input  logic      intEnable,
   input  logic      intReq,
   output logic      issueValid,
   input  logic      issueReady,
   output addrT      issueAddr,
   output instrWordT issueWord,
   output opcodeT    opcode,
   output regIdxT    rd,
   output regIdxT    ra,
   output regIdxT    rb,
   output altT       alt,
   output instrWordT simm
);

   logic [1:0] intSync;
   logic intSeen;
   logic intPending;
   logic immPending;
   logic [15:0] immHigh;
   logic issueLong;
   logic lastBlocksInt;
   logic canAccept;
   logic load;
   logic inject;
   instrWordT slotWord;
   opcodeT slotOp;
   instrWordT slotSimm;
   logic slotLong;
   logic slotBlocksInt;

   // Two-flop synchroniser, only samples while enabled
   always_ff @(posedge gclk) begin
      if (grst) begin
         intSync <= 2'b00;
         intSeen <= 1'b0;
      end else if (intEnable) begin
         intSync <= {intSync[0], intReq};
         intSeen <= intSync[1];
      end
   end

   // Pending latch, runs regardless of stalls
   // One vector per rising request level
   always_ff @(posedge gclk) begin
      if (grst) begin
         intPending <= 1'b0;
      end else if (load && inject) begin
         intPending <= 1'b0;
      end else begin
         intPending <= (intPending || (intSync[1] && !intSeen)) && intEnable;
      end
   end

   // Slot free when empty, or draining a single-cycle op
   assign canAccept = !issueValid || (issueReady && !issueLong);
   assign load = canAccept && headValid;

   // Never after an IMM prefix, nor into a delay slot
   assign inject = intPending && !lastBlocksInt;

   // Injected slot leaves the head in the queue
   assign pop = load && !inject;

   assign slotWord = inject ? IntVectorOp : headWord;
   assign slotOp = slotWord[31:26];

   // Prefix bits go on top, else sign-extend the low half
   assign slotSimm = immPending ? {immHigh, slotWord[15:0]}
                                : {{16{slotWord[15]}}, slotWord[15:0]};

   // Multiply, barrel shift and memory ops take two cycles
   assign slotLong = (slotOp == OpMulA) || (slotOp == OpMulB) ||
                     (slotOp == OpBsfA) || (slotOp == OpBsfB) ||
                     isLoadStore(slotOp);

   assign slotBlocksInt = (slotOp == OpImm) || (slotOp == OpRtd) ||
                          (slotOp == OpBruA) || (slotOp == OpBruB) ||
                          (slotOp == OpBccA) || (slotOp == OpBccB);

   // Issue control state
   always_ff @(posedge gclk) begin
      if (grst) begin
         issueValid <= 1'b0;
         issueLong <= 1'b0;
         lastBlocksInt <= 1'b0;
         immPending <= 1'b0;
      end else if (load) begin
         issueValid <= 1'b1;
         issueLong <= slotLong;
         lastBlocksInt <= slotBlocksInt;
         immPending <= slotOp == OpImm;
      end else if (issueReady) begin
         // Transfer with nothing behind it, or a bubble cycle
         issueValid <= 1'b0;
      end
   end

   // Issue payload holds until the next accepted slot
   always_ff @(posedge gclk) begin
      if (load) begin
         issueAddr <= headAddr;
         issueWord <= slotWord;
         simm <= slotSimm;
      end
   end

   // Prefix half kept for the following instruction
   always_ff @(posedge gclk) begin
      if (load && (slotOp == OpImm)) begin
         immHigh <= slotWord[15:0];
      end
   end

   // Field split of the issued word
   assign opcode = issueWord[31:26];
   assign rd = issueWord[25:21];
   assign ra = issueWord[20:16];
   assign rb = issueWord[15:11];
   assign alt = issueWord[10:0];

endmodule

//--- rtl/fetchFront.sv
/*
 * Instruction front end top level
 * Fetch unit, fetch queue and instruction buffer in a row
 */
module fetchFront
   import fetchPkg::*;
(
   input  logic      gclk,
   input  logic      grst,
   output logic      imemReq,
   output addrT      imemAddr,
   input  instrWordT imemData,
   input  logic      intEnable,
   input  logic      intReq,
   output logic      issueValid,
   input  logic      issueReady,
   output addrT      issueAddr,
   output instrWordT issueWord,
   output opcodeT    opcode,
   output regIdxT    rd,
   output regIdxT    ra,
   output regIdxT    rb,
   output altT       alt,
   output instrWordT simm
);

   // Fetch to queue
   logic pushValid;
   addrT pushAddr;
   instrWordT pushWord;
   logic creditReturn;

   // Queue to instruction buffer
   logic headValid;
   addrT headAddr;
   instrWordT headWord;
   logic pop;

   fetchUnit u_fetchUnit (
      .gclk         (gclk),
      .grst         (grst),
      .imemReq      (imemReq),
      .imemAddr     (imemAddr),
      .imemData     (imemData),
      .pushValid    (pushValid),
      .pushAddr     (pushAddr),
      .pushWord     (pushWord),
      .creditReturn (creditReturn)
   );

   fetchQueue u_fetchQueue (
      .gclk         (gclk),
      .grst         (grst),
      .pushValid    (pushValid),
      .pushAddr     (pushAddr),
      .pushWord     (pushWord),
      .headValid    (headValid),
      .headAddr     (headAddr),
      .headWord     (headWord),
      .pop          (pop),
      .creditReturn (creditReturn)
   );

   instrBuffer u_instrBuffer (
      .gclk       (gclk),
      .grst       (grst),
      .headValid  (headValid),
      .headAddr   (headAddr),
      .headWord   (headWord),
      .pop        (pop),
      .intEnable  (intEnable),
      .intReq     (intReq),
      .issueValid (issueValid),
      .issueReady (issueReady),
      .issueAddr  (issueAddr),
      .issueWord  (issueWord),
      .opcode     (opcode),
      .rd         (rd),
      .ra         (ra),
      .rb         (rb),
      .alt        (alt),
      .simm       (simm)
   );

endmodule

//--- tests/tbClock.sv
/*
 * Testbench clock and reset
 * 4 ns clock, reset held high for the first four cycles
 */
module tbClock (
   output logic gclk,
   output logic grst
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      gclk = 1'b0;
      forever begin
         #2 gclk = ~gclk;
      end
   end

   // Release on a falling edge, away from the DUT sampling edge
   initial begin
      grst = 1'b1;
      repeat (4) @(posedge gclk);
      @(negedge gclk);
      grst = 1'b0;
   end

endmodule

//--- tests/fetchTb.sv
/*
 * Fetch front end testbench
 * Memory model, program image and directed tests on the issue port
 */
module fetchTb
   import fetchPkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TransferTimeout = 60;
   localparam int ImageWords = 64;

   logic gclk;
   logic grst;
   logic imemReq;
   addrT imemAddr;
   instrWordT imemData;
   logic intEnable;
   logic intReq;
   logic issueValid;
   logic issueReady;
   addrT issueAddr;
   instrWordT issueWord;
   opcodeT opcode;
   regIdxT rd;
   regIdxT ra;
   regIdxT rb;
   altT alt;
   instrWordT simm;

   instrWordT image [ImageWords];
   logic [31:0] lcgState;
   int errors;
   int checks;
   int vectorCount;
   int immMerges;
   int stallCheck;
   addrT expAddr;
   addrT fetchAddr;
   logic prevImm;
   logic [15:0] prevLow;
   opcodeT lastOp;

   tbClock u_tbClock (
      .gclk (gclk),
      .grst (grst)
   );

   fetchFront u_fetchFront (
      .gclk       (gclk),
      .grst       (grst),
      .imemReq    (imemReq),
      .imemAddr   (imemAddr),
      .imemData   (imemData),
      .intEnable  (intEnable),
      .intReq     (intReq),
      .issueValid (issueValid),
      .issueReady (issueReady),
      .issueAddr  (issueAddr),
      .issueWord  (issueWord),
      .opcode     (opcode),
      .rd         (rd),
      .ra         (ra),
      .rb         (rb),
      .alt        (alt),
      .simm       (simm)
   );

   // Memory answers one cycle after each request, image repeats every 256 bytes
   always @(posedge gclk) begin
      if (imemReq) begin
         imemData <= image[imemAddr[7:2]];
      end
   end

   // Requests walk the addresses in order and never run past the queue credits
   always @(negedge gclk) begin
      if (imemReq === 1'b1) begin
         compareAddr("fetch", "imem addr", fetchAddr, imemAddr);
         fetchAddr = fetchAddr + addrT'(4);
         if (((fetchAddr - expAddr) >> 2) > addrT'(QueueDepth + 1)) begin
            $display("fetch: more than %0d words requested ahead of issue", QueueDepth + 1);
            errors++;
         end
      end
   end

   function automatic logic [15:0] lcgNext();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[30:15];
   endfunction

   // Multiply, barrel shift, load and store
   function automatic logic longOp(input opcodeT op);
      return (op == OpMulA) || (op == OpMulB) || (op == OpBsfA) || (op == OpBsfB) ||
             (op[5:4] == 2'b11);
   endfunction

   function automatic logic blocksInt(input opcodeT op);
      return (op == OpImm) || (op == OpRtd) || (op == OpBruA) || (op == OpBruB) ||
             (op == OpBccA) || (op == OpBccB);
   endfunction

   function automatic instrWordT makeWord(input opcodeT op, input logic signBit);
      instrWordT w;
      logic [15:0] hi;
      logic [15:0] lo;
      hi = lcgNext();
      lo = lcgNext();
      w = {op, hi[9:0], lo};
      w[15] = signBit;
      return w;
   endfunction

   // Arithmetic body, a two-cycle block, IMM pairs, then branches
   task automatic buildImage();
      opcodeT branchOps [5];
      opcodeT longOps [8];
      branchOps = '{OpBruA, OpBccA, OpBccB, OpRtd, OpBruB};
      longOps = '{OpMulA, 6'o00, OpBsfB, 6'o62, 6'o05, 6'o66, OpMulB, OpBsfA};
      for (int i = 0; i < ImageWords; i++) begin
         image[i] = makeWord(opcodeT'(lcgNext() % 16), i[0]);
      end
      for (int i = 16; i < 24; i++) begin
         image[i] = makeWord(longOps[i-16], i[1]);
      end
      image[24] = makeWord(OpImm, 1'b1);
      image[26] = makeWord(OpImm, 1'b0);
      image[28] = makeWord(OpImm, 1'b1);
      image[29] = makeWord(6'o72, 1'b0);
      for (int i = 33; i < 48; i += 2) begin
         image[i] = makeWord(branchOps[(i / 2) % 5], 1'b0);
         if (image[i] == IntVectorOp) begin
            image[i][0] = 1'b1;
         end
      end
   endtask

   task automatic compareWord(input string testName, input string what,
                              input instrWordT expected, input instrWordT actual);
      checks++;
      if (expected !== actual) begin
         $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
         errors++;
      end
   endtask

   task automatic compareAddr(input string testName, input string what,
                              input addrT expected, input addrT actual);
      checks++;
      if (expected !== actual) begin
         $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
         errors++;
      end
   endtask

   task automatic compareField(input string testName, input string what,
                               input opcodeT expected, input opcodeT actual);
      checks++;
      if (expected !== actual) begin
         $display("** Error %s %s: expected %h, actual %h", testName, what, expected, actual);
         errors++;
      end
   endtask

   // One transfer seen at the falling edge before it happens
   task automatic checkTransfer(input string testName, input logic stallMode);
      instrWordT expWord;
      instrWordT expSimm;
      if (issueWord === IntVectorOp) begin
         vectorCount++;
         expWord = IntVectorOp;
         if (blocksInt(lastOp)) begin
            $display("%s: interrupt vector issued right after IMM, return or branch", testName);
            errors++;
         end
         compareAddr(testName, "vector addr", expAddr, issueAddr);
      end else begin
         expWord = image[expAddr[7:2]];
         compareAddr(testName, "addr", expAddr, issueAddr);
         expAddr = expAddr + addrT'(4);
      end
      compareWord(testName, "word", expWord, issueWord);
      compareField(testName, "opcode", expWord[31:26], opcode);
      compareField(testName, "rd", opcodeT'(expWord[25:21]), opcodeT'(rd));
      compareField(testName, "ra", opcodeT'(expWord[20:16]), opcodeT'(ra));
      compareField(testName, "rb", opcodeT'(expWord[15:11]), opcodeT'(rb));
      compareWord(testName, "alt", instrWordT'(expWord[10:0]), instrWordT'(alt));
      if (prevImm) begin
         expSimm = {prevLow, expWord[15:0]};
         immMerges++;
      end else begin
         expSimm = {{16{expWord[15]}}, expWord[15:0]};
      end
      compareWord(testName, "simm", expSimm, simm);
      prevImm = expWord[31:26] == OpImm;
      prevLow = expWord[15:0];
      lastOp = expWord[31:26];
      if (stallMode) begin
         if (longOp(lastOp)) begin
            stallCheck = 1;
         end else if (u_fetchFront.headValid) begin
            stallCheck = 2;
         end
      end
   endtask

   task automatic nextTransfer(input string testName, input logic randomReady,
                               input logic stallMode);
      int waitCount;
      logic got;
      logic [15:0] r;
      waitCount = 0;
      got = 1'b0;
      while (!got && waitCount < TransferTimeout) begin
         @(negedge gclk);
         waitCount++;
         if (stallCheck == 1 && issueValid) begin
            $display("%s: issueValid high in the bubble after a two-cycle op", testName);
            errors++;
         end
         if (stallCheck == 2 && !issueValid) begin
            $display("%s: issueValid dropped after a single-cycle op", testName);
            errors++;
         end
         stallCheck = 0;
         // Ready for the coming rising edge
         r = lcgNext();
         issueReady = randomReady ? r[7] : 1'b1;
         if (issueValid && issueReady) begin
            got = 1'b1;
            checkTransfer(testName, stallMode);
         end
      end
      if (!got) begin
         $display("%s: no transfer within %0d cycles", testName, TransferTimeout);
         errors++;
      end
   endtask

   task automatic runTest(input string testName, input int count, input logic randomReady,
                          input logic stallMode, input int vectorsExpected);
      int startErrors;
      startErrors = errors;
      vectorCount = 0;
      for (int i = 0; i < count; i++) begin
         nextTransfer(testName, randomReady, stallMode);
      end
      if (vectorsExpected >= 0 && vectorCount != vectorsExpected) begin
         $display("%s: %0d interrupt vectors issued, %0d wanted", testName,
                  vectorCount, vectorsExpected);
         errors++;
      end
      $display("%s: %0d transfers, %0d errors", testName, count, errors - startErrors);
   endtask

   // Request lands while the alternating branch block passes through
   task automatic interruptTest();
      int startErrors;
      int guard;
      startErrors = errors;
      intReq = 1'b0;
      intEnable = 1'b1;
      runTest("intFlush", 37, 1'b0, 1'b0, 0);
      intReq = 1'b1;
      vectorCount = 0;
      guard = 0;
      while (vectorCount == 0 && guard < 80) begin
         nextTransfer("interrupt", 1'b0, 1'b0);
         guard++;
      end
      intReq = 1'b0;
      for (int i = 0; i < 20; i++) begin
         nextTransfer("interrupt", 1'b0, 1'b0);
      end
      if (vectorCount != 1) begin
         $display("interrupt: %0d interrupt vectors issued, 1 wanted", vectorCount);
         errors++;
      end
      $display("interrupt: %0d errors", errors - startErrors);
   endtask

   initial begin
      int waitCount;
      lcgState = 32'd38;
      errors = 0;
      checks = 0;
      stallCheck = 0;
      immMerges = 0;
      expAddr = '0;
      fetchAddr = '0;
      prevImm = 1'b0;
      prevLow = '0;
      lastOp = '0;
      imemData = '0;
      intEnable = 1'b0;
      intReq = 1'b0;
      issueReady = 1'b1;
      buildImage();
      waitCount = 0;
      while (grst !== 1'b0 && waitCount < 20) begin
         @(negedge gclk);
         waitCount++;
      end
      if (grst !== 1'b0) begin
         $display("reset never released");
         errors++;
      end
      runTest("seqDecode", 16, 1'b0, 1'b0, 0);
      runTest("twoCycleStall", 8, 1'b0, 1'b1, 0);
      immMerges = 0;
      runTest("immForm", 8, 1'b0, 1'b0, 0);
      if (immMerges != 3) begin
         $display("immForm: %0d IMM merges seen, 3 wanted", immMerges);
         errors++;
      end
      runTest("backPressure", 60, 1'b1, 1'b0, 0);
      intReq = 1'b1;
      runTest("intMasked", 30, 1'b0, 1'b0, 0);
      interruptTest();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- build.f
rtl/fetchPkg.sv
rtl/fetchUnit.sv
rtl/fetchQueue.sv
rtl/instrBuffer.sv
rtl/fetchFront.sv
tests/tbClock.sv
tests/fetchTb.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module fetchTb -f build.f -o simv > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || { echo "Simulation run failed, see sim.log"; exit 1; }
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
